/* compile.f */
+incdir+testbench
design/rv_isa_pkg.sv
design/decode_ctrl_pkg.sv
design/opcode_decode.sv
design/alu_op_decode.sv
design/imm_gen.sv
design/rv_decoder.sv
testbench/tb_rv_decoder.sv

/* design/alu_op_decode.sv */
`timescale 1ns/1ns

module alu_op_decode (
   input  rv_isa_pkg::op_class_e    i_class,
   input  rv_isa_pkg::funct3_t      i_funct3,
   input  rv_isa_pkg::funct7_t      i_funct7,
   output decode_ctrl_pkg::alu_op_e o_alu_op
);

   import rv_isa_pkg::*;
   import decode_ctrl_pkg::*;

   // base RV32I op, alt bits pick sub and sra
   function automatic alu_op_e base_op(input funct3_t f3, input logic sub, input logic sra);
      case (f3)
         F3_ADD_SUB: base_op = sub ? ALU_SUB : ALU_ADD;
         F3_SLL:     base_op = ALU_SLL;
         F3_SLT:     base_op = ALU_SLT;
         F3_SLTU:    base_op = ALU_SLTU;
         F3_XOR:     base_op = ALU_XOR;
         F3_SRL_SRA: base_op = sra ? ALU_SRA : ALU_SRL;
         F3_OR:      base_op = ALU_OR;
         default:    base_op = ALU_AND;
      endcase
   endfunction

   // M extension, same funct3 slots
   function automatic alu_op_e muldiv_op(input funct3_t f3);
      case (f3)
         F3_ADD_SUB: muldiv_op = ALU_MUL;
         F3_SLL:     muldiv_op = ALU_MULH;
         F3_SLT:     muldiv_op = ALU_MULHSU;
         F3_SLTU:    muldiv_op = ALU_MULHU;
         F3_XOR:     muldiv_op = ALU_DIV;
         F3_SRL_SRA: muldiv_op = ALU_DIVU;
         F3_OR:      muldiv_op = ALU_REM;
         default:    muldiv_op = ALU_REMU;
      endcase
   endfunction

   logic alt; // full funct7 match for register ops

   assign alt = (i_funct7 == FUNCT7_ALT);

   always_comb begin
      case (i_class)
         CLS_OP: begin
            if (i_funct7 == FUNCT7_MULDIV)
               o_alu_op = muldiv_op(i_funct3);
            else
               o_alu_op = base_op(i_funct3, alt, alt);
         end
         // no subi, only srai looks at bit 30
         CLS_OPIMM: o_alu_op = base_op(i_funct3, 1'b0, i_funct7[5]);
         default:   o_alu_op = ALU_ADD; // addresses, links, auipc
      endcase
   end

endmodule

/* design/decode_ctrl_pkg.sv */
package decode_ctrl_pkg;

   import rv_isa_pkg::*;

   // alu operations, add must stay at zero
   typedef enum logic [4:0] {
      ALU_ADD    = 5'd0,
      ALU_SUB    = 5'd1,
      ALU_SLL    = 5'd2,
      ALU_SLT    = 5'd3,
      ALU_SLTU   = 5'd4,
      ALU_XOR    = 5'd5,
      ALU_SRL    = 5'd6,
      ALU_SRA    = 5'd7,
      ALU_OR     = 5'd8,
      ALU_AND    = 5'd9,
      ALU_MUL    = 5'd10,
      ALU_MULH   = 5'd11,
      ALU_MULHSU = 5'd12,
      ALU_MULHU  = 5'd13,
      ALU_DIV    = 5'd14,
      ALU_DIVU   = 5'd15,
      ALU_REM    = 5'd16,
      ALU_REMU   = 5'd17
   } alu_op_e;

   typedef enum logic {
      SRC1_REG = 1'b0, // rs1 value
      SRC1_PC  = 1'b1
   } alu_src1_e;

   typedef enum logic [1:0] {
      SRC2_REG = 2'd0, // rs2 value
      SRC2_IMM = 2'd1
   } alu_src2_e;

   // register file write data mux
   typedef enum logic [1:0] {
      REGIN_ALU = 2'd0,
      REGIN_IMM = 2'd1
   } reg_input_e;

   // where the multi-cycle core goes after execute
   typedef enum logic [2:0] {
      NEXT_FETCH  = 3'd0,
      NEXT_LOAD   = 3'd1,
      NEXT_STORE  = 3'd2,
      NEXT_BRANCH = 3'd3,
      NEXT_SYSTEM = 3'd4,
      NEXT_TRAP   = 3'd5
   } next_stage_e;

   localparam int BR_MASK_W = 6;
   typedef logic [BR_MASK_W-1:0] branch_mask_t; // one-hot compare select

   // bit positions inside branch_mask_t
   localparam int BR_BEQ  = 0;
   localparam int BR_BNE  = 1;
   localparam int BR_BLT  = 2;
   localparam int BR_BGE  = 3;
   localparam int BR_BLTU = 4;
   localparam int BR_BGEU = 5;

   typedef struct packed {
      alu_src1_e   src1_sel;
      alu_src2_e   src2_sel;
      next_stage_e next_stage;
      logic        wb_from_alu;      // write rd from alu in fetch
      logic        wb_from_imm;      // write rd straight from imm
      logic        next_pc_from_alu; // jumps
      reg_input_e  reg_input_sel;
      logic        write_reg;        // link write during execute
   } exec_ctrl_t;

   // contents of the decode register, all zero is a harmless bubble
   typedef struct packed {
      word_t        imm;
      alu_op_e      alu_op;
      exec_ctrl_t   ctrl;
      branch_mask_t branch_mask;
      funct3_t      funct3;  // load/store width for the memory stages
      reg_idx_t     rd;
   } decode_out_t;

endpackage

/* design/imm_gen.sv */
`timescale 1ns/1ns

module imm_gen (
   input  rv_isa_pkg::op_class_e i_class,
   input  rv_isa_pkg::instr_t    i_instr,
   output rv_isa_pkg::word_t     o_imm
);

   import rv_isa_pkg::*;

   logic sgn; // every signed format takes bit 31

   assign sgn = i_instr[31];

   always_comb begin
      case (i_class)
         CLS_STORE: begin // S-type
            o_imm = {{20{sgn}}, i_instr[31:25], i_instr[11:7]};
         end
         CLS_BRANCH: begin // B-type, halfword offset
            o_imm = {{19{sgn}}, i_instr[31], i_instr[7], i_instr[30:25],
                     i_instr[11:8], 1'b0};
         end
         CLS_LUI, CLS_AUIPC: begin
            o_imm = {i_instr[31:12], 12'b0}; // U-type, no extension needed
         end
         CLS_JAL: begin
            // J-type, scrambled like B but over 20 bits
            o_imm = {{11{sgn}}, i_instr[31], i_instr[19:12], i_instr[20],
                     i_instr[30:21], 1'b0};
         end
         default: begin
            // I-type, also covers jalr, loads and shifts
            // meaningless for R-type, harmless there
            o_imm = {{20{sgn}}, i_instr[31:20]};
         end
      endcase
   end

endmodule

/* design/opcode_decode.sv */
`timescale 1ns/1ns

module opcode_decode (
   input  rv_isa_pkg::instr_t           i_instr,
   output rv_isa_pkg::op_class_e        o_class,
   output decode_ctrl_pkg::exec_ctrl_t  o_ctrl,
   output decode_ctrl_pkg::branch_mask_t o_branch_mask
);

   import rv_isa_pkg::*;
   import decode_ctrl_pkg::*;

   opcode_t opcode;
   funct3_t funct3;
   logic    full_len; // low bits 11, i.e. a 32-bit encoding

   assign opcode   = i_instr[6:2];
   assign funct3   = i_instr[14:12];
   assign full_len = (i_instr[1:0] == 2'b11);

   // opcode -> class, anything unknown traps
   always_comb begin
      o_class = CLS_ILLEGAL;
      if (full_len) begin
         case (opcode)
            OP_OP:      o_class = CLS_OP;
            OP_OPIMM:   o_class = CLS_OPIMM;
            OP_LOAD:    o_class = CLS_LOAD;
            OP_STORE:   o_class = CLS_STORE;
            OP_JAL:     o_class = CLS_JAL;
            OP_JALR:    o_class = CLS_JALR;
            OP_BRANCH:  o_class = CLS_BRANCH;
            OP_AUIPC:   o_class = CLS_AUIPC;
            OP_LUI:     o_class = CLS_LUI;
            OP_MISCMEM: o_class = CLS_MISCMEM;
            OP_SYSTEM:  o_class = CLS_SYSTEM;
            default:    o_class = CLS_ILLEGAL;
         endcase
      end
   end

   // class -> execute control
   always_comb begin
      o_ctrl = '0; // reg sources, fetch, no writes
      case (o_class)
         CLS_OP: begin
            o_ctrl.wb_from_alu = 1'b1; // writeback happens in fetch
         end
         CLS_OPIMM: begin
            o_ctrl.src2_sel    = SRC2_IMM;
            o_ctrl.wb_from_alu = 1'b1;
         end
         CLS_LOAD: begin // address = rs1 + imm
            o_ctrl.src2_sel   = SRC2_IMM;
            o_ctrl.next_stage = NEXT_LOAD;
         end
         CLS_STORE: begin
            o_ctrl.src2_sel   = SRC2_IMM;
            o_ctrl.next_stage = NEXT_STORE;
         end
         CLS_JAL, CLS_JALR: begin
            // link value written now, target from alu
            o_ctrl.write_reg        = 1'b1;
            o_ctrl.reg_input_sel    = REGIN_ALU;
            o_ctrl.src1_sel         = (o_class == CLS_JAL) ? SRC1_PC : SRC1_REG;
            o_ctrl.src2_sel         = SRC2_IMM;
            o_ctrl.next_pc_from_alu = 1'b1;
         end
         CLS_BRANCH: begin
            o_ctrl.next_stage = NEXT_BRANCH; // compare rs1 vs rs2
         end
         CLS_AUIPC: begin
            o_ctrl.src1_sel    = SRC1_PC;
            o_ctrl.src2_sel    = SRC2_IMM;
            o_ctrl.wb_from_alu = 1'b1;
         end
         CLS_LUI: begin
            o_ctrl.wb_from_imm   = 1'b1;
            o_ctrl.reg_input_sel = REGIN_IMM;
         end
         CLS_MISCMEM: o_ctrl.next_stage = NEXT_FETCH; // fence is a nop here
         CLS_SYSTEM:  o_ctrl.next_stage = NEXT_SYSTEM;
         default:     o_ctrl.next_stage = NEXT_TRAP;
      endcase
   end

   // one-hot compare select, only for branches
   always_comb begin
      o_branch_mask = '0;
      if (o_class == CLS_BRANCH) begin
         case (funct3)
            F3_BEQ:  o_branch_mask[BR_BEQ]  = 1'b1;
            F3_BNE:  o_branch_mask[BR_BNE]  = 1'b1;
            F3_BLT:  o_branch_mask[BR_BLT]  = 1'b1;
            F3_BGE:  o_branch_mask[BR_BGE]  = 1'b1;
            F3_BLTU: o_branch_mask[BR_BLTU] = 1'b1;
            F3_BGEU: o_branch_mask[BR_BGEU] = 1'b1;
            default: o_branch_mask = '0; // 010/011 never taken
         endcase
      end
   end

endmodule

/* design/rv_decoder.sv */
`timescale 1ns/1ns

module rv_decoder (
   input  logic                         i_clk,
   input  logic                         i_rst,
   input  logic                         i_en,     // capture strobe from the core FSM
   input  rv_isa_pkg::instr_t           i_instr,
   output rv_isa_pkg::reg_idx_t         o_rs1,
   output rv_isa_pkg::reg_idx_t         o_rs2,
   output decode_ctrl_pkg::decode_out_t o_dec
);

   import rv_isa_pkg::*;
   import decode_ctrl_pkg::*;

   op_class_e    op_class;
   exec_ctrl_t   ctrl;
   branch_mask_t branch_mask;
   alu_op_e      alu_op;
   word_t        imm;
   decode_out_t  dec_d;
   decode_out_t  dec_q;

   // register file read starts during decode
   assign o_rs1 = i_instr[19:15];
   assign o_rs2 = i_instr[24:20];

   opcode_decode opcode_decode_i (
      .i_instr       (i_instr),
      .o_class       (op_class),
      .o_ctrl        (ctrl),
      .o_branch_mask (branch_mask)
   );

   alu_op_decode alu_op_decode_i (
      .i_class  (op_class),
      .i_funct3 (i_instr[14:12]),
      .i_funct7 (i_instr[31:25]),
      .o_alu_op (alu_op)
   );

   imm_gen imm_gen_i (
      .i_class (op_class),
      .i_instr (i_instr),
      .o_imm   (imm)
   );

   // next decode record
   always_comb begin
      dec_d.imm         = imm;
      dec_d.alu_op      = alu_op;
      dec_d.ctrl        = ctrl;
      dec_d.branch_mask = branch_mask;
      dec_d.funct3      = i_instr[14:12];
      dec_d.rd          = i_instr[11:7];
   end

   always_ff @(posedge i_clk) begin
      if (i_rst)
         dec_q <= '0;      // bubble: fetch, no writes, no branch
      else if (i_en)
         dec_q <= dec_d;   // holds while the core stalls
   end

   assign o_dec = dec_q;

endmodule

/* design/rv_isa_pkg.sv */
package rv_isa_pkg;

   // widths
   localparam int XLEN      = 32;
   localparam int REG_IDX_W = 5;
   localparam int OPCODE_W  = 5;  // instr[6:2], low two bits checked separately
   localparam int FUNCT3_W  = 3;
   localparam int FUNCT7_W  = 7;

   typedef logic [XLEN-1:0]      word_t;     // data or immediate
   typedef logic [31:0]          instr_t;    // always a full 32-bit encoding
   typedef logic [REG_IDX_W-1:0] reg_idx_t;
   typedef logic [OPCODE_W-1:0]  opcode_t;
   typedef logic [FUNCT3_W-1:0]  funct3_t;
   typedef logic [FUNCT7_W-1:0]  funct7_t;

   // major opcodes, bits 6:2
   localparam opcode_t OP_LOAD    = 5'b00000;
   localparam opcode_t OP_MISCMEM = 5'b00011; // fence
   localparam opcode_t OP_OPIMM   = 5'b00100;
   localparam opcode_t OP_AUIPC   = 5'b00101;
   localparam opcode_t OP_STORE   = 5'b01000;
   localparam opcode_t OP_OP      = 5'b01100; // also carries M ops
   localparam opcode_t OP_LUI     = 5'b01101;
   localparam opcode_t OP_BRANCH  = 5'b11000;
   localparam opcode_t OP_JALR    = 5'b11001;
   localparam opcode_t OP_JAL     = 5'b11011;
   localparam opcode_t OP_SYSTEM  = 5'b11100;

   // alu funct3, shared by OP and OP-IMM
   localparam funct3_t F3_ADD_SUB = 3'b000;
   localparam funct3_t F3_SLL     = 3'b001;
   localparam funct3_t F3_SLT     = 3'b010;
   localparam funct3_t F3_SLTU    = 3'b011;
   localparam funct3_t F3_XOR     = 3'b100;
   localparam funct3_t F3_SRL_SRA = 3'b101;
   localparam funct3_t F3_OR      = 3'b110;
   localparam funct3_t F3_AND     = 3'b111;

   // branch funct3, 010 and 011 unused
   localparam funct3_t F3_BEQ  = 3'b000;
   localparam funct3_t F3_BNE  = 3'b001;
   localparam funct3_t F3_BLT  = 3'b100;
   localparam funct3_t F3_BGE  = 3'b101;
   localparam funct3_t F3_BLTU = 3'b110;
   localparam funct3_t F3_BGEU = 3'b111;

   localparam funct7_t FUNCT7_ALT    = 7'b0100000; // sub / sra
   localparam funct7_t FUNCT7_MULDIV = 7'b0000001; // M extension

   // instruction class, the only view of the opcode past opcode_decode
   typedef enum logic [3:0] {
      CLS_OP,
      CLS_OPIMM,
      CLS_LOAD,
      CLS_STORE,
      CLS_JAL,
      CLS_JALR,
      CLS_BRANCH,
      CLS_AUIPC,
      CLS_LUI,
      CLS_MISCMEM,
      CLS_SYSTEM,
      CLS_ILLEGAL
   } op_class_e;

endpackage

/* testbench/tb_rv_model.svh */
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

// per-funct3 lookups, entry 0 is the rightmost one
localparam logic [7:0][4:0] BASE_OPS = {ALU_AND, ALU_OR, ALU_SRL, ALU_XOR,
                                        ALU_SLTU, ALU_SLT, ALU_SLL, ALU_ADD};
localparam logic [7:0][4:0] MULDIV_OPS = {ALU_REMU, ALU_REM, ALU_DIVU, ALU_DIV,
                                          ALU_MULHU, ALU_MULHSU, ALU_MULH, ALU_MUL};
localparam logic [7:0][5:0] BR_MASKS = {6'b100000, 6'b010000, 6'b001000, 6'b000100,
                                        6'b000000, 6'b000000, 6'b000010, 6'b000001};

// copy bit w-1 upward
function automatic word_t sext(input word_t v, input int w);
   word_t r;
   r = v;
   for (int b = w; b < XLEN; b++)
      r[b] = v[w-1];
   return r;
endfunction

function automatic instr_t enc_r(input funct7_t f7, input reg_idx_t rs2, input reg_idx_t rs1,
                                 input funct3_t f3, input reg_idx_t rd, input opcode_t op);
   return {f7, rs2, rs1, f3, rd, op, 2'b11};
endfunction

function automatic instr_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                 input funct3_t f3, input reg_idx_t rd, input opcode_t op);
   return {imm, rs1, f3, rd, op, 2'b11};
endfunction

function automatic instr_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                 input reg_idx_t rs1, input funct3_t f3);
   return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE, 2'b11};
endfunction

// imm[0] is dropped by the format
function automatic instr_t enc_b(input logic [12:0] imm, input reg_idx_t rs2,
                                 input reg_idx_t rs1, input funct3_t f3);
   return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH, 2'b11};
endfunction

function automatic instr_t enc_u(input logic [19:0] imm, input reg_idx_t rd, input opcode_t op);
   return {imm, rd, op, 2'b11};
endfunction

function automatic instr_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
   return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL, 2'b11};
endfunction

// expected decode record, imm supplied by the caller from the encoded value
function automatic decode_out_t expect_dec(input instr_t ins, input word_t imm);
   decode_out_t d;
   funct3_t     f3;
   funct7_t     f7;
   f3 = ins[14:12];
   f7 = ins[31:25];
   d = '0;
   d.imm = imm;
   d.funct3 = f3;
   d.rd = ins[11:7];
   d.ctrl.next_stage = NEXT_TRAP; // 16-bit encodings stay here
   if (ins[1:0] == 2'b11) begin
      d.ctrl.next_stage = NEXT_FETCH;
      case (ins[6:2])
         OP_OP: begin
            d.ctrl.wb_from_alu = 1'b1;
            d.alu_op = alu_op_e'(BASE_OPS[f3]);
            if (f7 == FUNCT7_MULDIV)
               d.alu_op = alu_op_e'(MULDIV_OPS[f3]);
            else if (f7 == FUNCT7_ALT && f3 == F3_ADD_SUB)
               d.alu_op = ALU_SUB;
            else if (f7 == FUNCT7_ALT && f3 == F3_SRL_SRA)
               d.alu_op = ALU_SRA;
         end
         OP_OPIMM: begin
            d.ctrl.src2_sel = SRC2_IMM;
            d.ctrl.wb_from_alu = 1'b1;
            d.alu_op = alu_op_e'(BASE_OPS[f3]);
            if (f3 == F3_SRL_SRA && ins[30])
               d.alu_op = ALU_SRA; // srai
         end
         OP_LOAD: begin
            d.ctrl.src2_sel = SRC2_IMM;
            d.ctrl.next_stage = NEXT_LOAD;
         end
         OP_STORE: begin
            d.ctrl.src2_sel = SRC2_IMM;
            d.ctrl.next_stage = NEXT_STORE;
         end
         OP_JAL, OP_JALR: begin
            d.ctrl.write_reg = 1'b1;
            d.ctrl.next_pc_from_alu = 1'b1;
            d.ctrl.src2_sel = SRC2_IMM;
            d.ctrl.src1_sel = (ins[6:2] == OP_JAL) ? SRC1_PC : SRC1_REG;
         end
         OP_BRANCH: begin
            d.ctrl.next_stage = NEXT_BRANCH;
            d.branch_mask = BR_MASKS[f3];
         end
         OP_AUIPC: begin
            d.ctrl.src1_sel = SRC1_PC;
            d.ctrl.src2_sel = SRC2_IMM;
            d.ctrl.wb_from_alu = 1'b1;
         end
         OP_LUI: begin
            d.ctrl.wb_from_imm = 1'b1;
            d.ctrl.reg_input_sel = REGIN_IMM;
         end
         OP_MISCMEM: ; // fence, nothing to do
         OP_SYSTEM: d.ctrl.next_stage = NEXT_SYSTEM;
         default: d.ctrl.next_stage = NEXT_TRAP;
      endcase
   end
   return d;
endfunction

`endif

/* testbench/tb_rv_decoder.sv */
`timescale 1ns/1ns

module tb_rv_decoder;

   import rv_isa_pkg::*;
   import decode_ctrl_pkg::*;

   localparam logic [31:0] SEED = 32'hf81e9b63;
   localparam int REPS = 40; // random rounds per looped test
   // reset, hold, reg ops, looped tests, other classes
   localparam int TEST_CYCLES = 8 + 11 + 24 + 23 * REPS + 38;
   localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

   `include "tb_rv_model.svh"

   logic        clk;
   logic        rst;
   logic        en;
   instr_t      instr;
   reg_idx_t    rs1;
   reg_idx_t    rs2;
   decode_out_t dec;

   int cycles = 0;
   int test_errs = 0;    // current test only
   int total_errs = 0;
   int tests_run = 0;
   int tests_failed = 0;

   rv_decoder rv_decoder_i (
      .i_clk   (clk),
      .i_rst   (rst),
      .i_en    (en),
      .i_instr (instr),
      .o_rs1   (rs1),
      .o_rs2   (rs2),
      .o_dec   (dec)
   );

   initial clk = 1'b0;
   always #20 clk = ~clk; // 40 ns period

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout: decoder tests still running after %0d cycles", cycles);
         $display("TEST FAILED");
         $finish;
      end
   end

   function automatic reg_idx_t rand_reg();
      return reg_idx_t'($urandom);
   endfunction

   task automatic check_rs(input string name, input reg_idx_t got, input reg_idx_t exp);
      if (got !== exp) begin
         $display("error %s: got %h expected %h", name, got, exp);
         test_errs++;
      end
   endtask

   task automatic check_dec(input decode_out_t got, input decode_out_t exp);
      if (got.imm !== exp.imm)
         $display("error o_dec.imm: got %h expected %h", got.imm, exp.imm);
      if (got.alu_op !== exp.alu_op)
         $display("error o_dec.alu_op: got %h expected %h", got.alu_op, exp.alu_op);
      if (got.ctrl !== exp.ctrl)
         $display("error o_dec.ctrl: got %h expected %h", got.ctrl, exp.ctrl);
      if (got.branch_mask !== exp.branch_mask)
         $display("error o_dec.branch_mask: got %h expected %h",
                  got.branch_mask, exp.branch_mask);
      if (got.funct3 !== exp.funct3)
         $display("error o_dec.funct3: got %h expected %h", got.funct3, exp.funct3);
      if (got.rd !== exp.rd)
         $display("error o_dec.rd: got %h expected %h", got.rd, exp.rd);
      if (got !== exp) begin
         $display("  last instr %h at %0t ns", instr, $time);
         test_errs++;
      end
   endtask

   // present with en high, result one edge later
   task automatic issue(input instr_t ins, input word_t imm);
      instr = ins;
      en = 1'b1;
      #1;
      check_rs("o_rs1", rs1, ins[19:15]); // same cycle
      check_rs("o_rs2", rs2, ins[24:20]);
      @(posedge clk);
      #2;
      en = 1'b0;
      check_dec(dec, expect_dec(ins, imm));
   endtask

   // en low, instr wanders, register must not move
   task automatic idle_cycle(input decode_out_t held);
      en = 1'b0;
      instr = $urandom;
      #1;
      check_rs("o_rs1", rs1, instr[19:15]);
      check_rs("o_rs2", rs2, instr[24:20]);
      @(posedge clk);
      #2;
      check_dec(dec, held);
   endtask

   task automatic report_test(input string name);
      tests_run++;
      if (test_errs == 0) begin
         $display("%s: ok", name);
      end else begin
         $display("%s: %0d errors", name, test_errs);
         tests_failed++;
      end
      total_errs += test_errs;
      test_errs = 0;
   endtask

   task automatic reset_and_hold();
      instr_t      ins;
      logic [11:0] imm;
      check_dec(dec, '0); // bubble straight out of reset
      repeat (6) idle_cycle('0);
      imm = 12'($urandom);
      ins = enc_i(imm, rand_reg(), F3_XOR, rand_reg(), OP_OPIMM);
      issue(ins, sext(imm, 12));
      repeat (4) idle_cycle(expect_dec(ins, sext(imm, 12)));
      report_test("reset and hold");
   endtask

   task automatic reg_alu_ops();
      funct7_t  f7;
      reg_idx_t r2;
      for (int k = 0; k < 3; k++) begin
         f7 = (k == 0) ? 7'b0 : (k == 1) ? FUNCT7_ALT : FUNCT7_MULDIV;
         for (int f = 0; f < 8; f++) begin
            r2 = rand_reg();
            // R-type still yields the I-immediate from bits 31:20
            issue(enc_r(f7, r2, rand_reg(), funct3_t'(f), rand_reg(), OP_OP),
                  sext({f7, r2}, 12));
         end
      end
      report_test("register alu and m ops");
   endtask

   task automatic imm_alu_ops();
      logic [11:0] imm;
      funct3_t     f3;
      for (int r = 0; r < REPS; r++) begin
         for (int f = 0; f < 9; f++) begin
            imm = 12'($urandom);
            if (f == 1 || f == 5)
               imm[11:5] = 7'b0;       // slli, srli
            if (f == 8)
               imm[11:5] = FUNCT7_ALT; // srai
            f3 = (f == 8) ? F3_SRL_SRA : funct3_t'(f);
            issue(enc_i(imm, rand_reg(), f3, rand_reg(), OP_OPIMM), sext(imm, 12));
         end
      end
      report_test("immediate alu ops");
   endtask

   task automatic mem_upper_forms();
      logic [11:0] imm;
      logic [19:0] upper;
      for (int r = 0; r < REPS; r++) begin
         imm = 12'($urandom);
         issue(enc_i(imm, rand_reg(), funct3_t'($urandom), rand_reg(), OP_LOAD), sext(imm, 12));
         imm = 12'($urandom);
         issue(enc_s(imm, rand_reg(), rand_reg(), funct3_t'($urandom)), sext(imm, 12));
         upper = 20'($urandom);
         issue(enc_u(upper, rand_reg(), OP_LUI), {upper, 12'b0});
         upper = 20'($urandom);
         issue(enc_u(upper, rand_reg(), OP_AUIPC), {upper, 12'b0});
      end
      report_test("memory and upper forms");
   endtask

   task automatic branch_jump_forms();
      logic [12:0] boff;
      logic [20:0] joff;
      logic [11:0] imm;
      for (int r = 0; r < REPS; r++) begin
         for (int f = 0; f < 8; f++) begin
            boff = 13'($urandom);
            boff[0] = 1'b0; // halfword aligned
            issue(enc_b(boff, rand_reg(), rand_reg(), funct3_t'(f)), sext(boff, 13));
         end
         joff = 21'($urandom);
         joff[0] = 1'b0;
         issue(enc_j(joff, rand_reg()), sext(joff, 21));
         imm = 12'($urandom);
         issue(enc_i(imm, rand_reg(), 3'b000, rand_reg(), OP_JALR), sext(imm, 12));
      end
      report_test("branches and jumps");
   endtask

   task automatic other_classes();
      logic [11:0] imm;
      logic [19:0] upper;
      instr_t      ins;
      imm = 12'($urandom);
      issue(enc_i(imm, rand_reg(), 3'b000, rand_reg(), OP_MISCMEM), sext(imm, 12));
      imm = 12'($urandom);
      issue(enc_i(imm, rand_reg(), 3'b000, rand_reg(), OP_SYSTEM), sext(imm, 12));
      for (int op = 0; op < 32; op++) begin // the 21 unused opcodes
         if (opcode_t'(op) inside {OP_LOAD, OP_MISCMEM, OP_OPIMM, OP_AUIPC, OP_STORE, OP_OP,
                                   OP_LUI, OP_BRANCH, OP_JALR, OP_JAL, OP_SYSTEM})
            continue;
         imm = 12'($urandom);
         issue(enc_i(imm, rand_reg(), funct3_t'($urandom), rand_reg(), opcode_t'(op)),
               sext(imm, 12));
      end
      for (int lo = 0; lo < 3; lo++) begin // compressed encodings trap
         ins = $urandom;
         ins[1:0] = 2'(lo);
         issue(ins, sext(ins[31:20], 12));
      end
      // back-to-back, en never low at an edge
      for (int k = 0; k < 6; k++) begin
         upper = 20'($urandom);
         issue(enc_u(upper, reg_idx_t'(k), OP_LUI), {upper, 12'b0});
         issue(enc_r(FUNCT7_ALT, 5'd7, 5'd6, F3_ADD_SUB, reg_idx_t'(k + 8), OP_OP),
               sext({FUNCT7_ALT, 5'd7}, 12));
      end
      report_test("other classes and throughput");
   endtask

   initial begin
      void'($urandom(SEED));
      rst = 1'b1;
      en = 1'b0;
      instr = '0;
      repeat (8) @(posedge clk);
      #2;
      rst = 1'b0;
      reset_and_hold();
      reg_alu_ops();
      imm_alu_ops();
      mem_upper_forms();
      branch_jump_forms();
      other_classes();
      $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, total_errs);
      if (total_errs == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule
